//--- logic/bmu_pkg.sv
// Bit-manipulation unit package
package bmu_pkg;

  //////////////////////////////
  // B extension subsets
  //////////////////////////////

  typedef enum logic [1:0] {
    NONE,            // No bit-manipulation support
    ZBA_ZBB_ZBS,     // Address gen, basic and single-bit ops
    ZBA_ZBB_ZBC_ZBS  // Adds carry-less multiply
  } b_ext_e;

  //////////////////////////////
  // ALU operators
  //////////////////////////////

  typedef enum logic [4:0] {
    ALU_B_SH1ADD,  // Zba shift-add group
    ALU_B_SH2ADD,
    ALU_B_SH3ADD,
    ALU_B_MIN,     // Zbb compare group
    ALU_B_MINU,
    ALU_B_MAX,
    ALU_B_MAXU,
    ALU_B_ANDN,    // Inverted logic
    ALU_B_ORN,
    ALU_B_XNOR,
    ALU_B_ROL,     // Rotations
    ALU_B_ROR,
    ALU_B_ZEXT_H,  // Extensions
    ALU_B_SEXT_B,
    ALU_B_SEXT_H,
    ALU_B_CLZ,     // Counts
    ALU_B_CTZ,
    ALU_B_CPOP,
    ALU_B_ORC_B,   // Byte ops
    ALU_B_REV8,
    ALU_B_CLMUL,   // Zbc
    ALU_B_CLMULH,
    ALU_B_CLMULR,
    ALU_B_BSET,    // Zbs
    ALU_B_BCLR,
    ALU_B_BINV,
    ALU_B_BEXT
  } alu_op_e;

  // Operand B source
  typedef enum logic {
    OP_B_REGB,  // RS2 register
    OP_B_IMM    // instr[24:20], zero-extended
  } op_b_sel_e;

  // Major opcodes handled here
  typedef enum logic [6:0] {
    OPCODE_OP    = 7'h33,
    OPCODE_OPIMM = 7'h13
  } opcode_e;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam logic [4:0] REG_RS1    = 5'h00;  // Operand A
  localparam logic [4:0] REG_RS2    = 5'h04;  // Operand B
  localparam logic [4:0] REG_INSTR  = 5'h08;  // Write issues the op
  localparam logic [4:0] REG_RESULT = 5'h0C;  // Read-only
  localparam logic [4:0] REG_STATUS = 5'h10;  // Read-only

  // STATUS bit positions
  localparam int STATUS_DONE_BIT    = 0;
  localparam int STATUS_ILLEGAL_BIT = 1;

endpackage : bmu_pkg

//--- logic/bmu_b_decoder.sv
// B extension decoder
`timescale 1ns/1ps

module bmu_b_decoder #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::NONE
) (
  input  logic [31:0]         instr_rdata_i,   // Instruction word
  output logic                illegal_insn_o,  // Unsupported or unmatched
  output bmu_pkg::alu_op_e    alu_operator_o,
  output bmu_pkg::op_b_sel_e  alu_op_b_sel_o
);

  // Group enables from the configured subset
  localparam bit RV32B_ZBA = (B_EXT == bmu_pkg::ZBA_ZBB_ZBS) ||
                             (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);
  localparam bit RV32B_ZBB = RV32B_ZBA;
  localparam bit RV32B_ZBS = RV32B_ZBA;
  localparam bit RV32B_ZBC = (B_EXT == bmu_pkg::ZBA_ZBB_ZBC_ZBS);

  always_comb begin
    // Illegal unless a match clears it
    illegal_insn_o = 1'b1;
    alu_operator_o = bmu_pkg::ALU_B_SH1ADD;
    alu_op_b_sel_o = bmu_pkg::OP_B_REGB;

    unique case (instr_rdata_i[6:0])

      //////////////////////////////
      // Register-register
      //////////////////////////////
      bmu_pkg::OPCODE_OP: begin
        unique case ({instr_rdata_i[31:25], instr_rdata_i[14:12]})
          // Zba
          {7'b0010000, 3'b010}: begin // sh1add
            illegal_insn_o = !RV32B_ZBA;
            alu_operator_o = bmu_pkg::ALU_B_SH1ADD;
          end
          {7'b0010000, 3'b100}: begin // sh2add
            illegal_insn_o = !RV32B_ZBA;
            alu_operator_o = bmu_pkg::ALU_B_SH2ADD;
          end
          {7'b0010000, 3'b110}: begin // sh3add
            illegal_insn_o = !RV32B_ZBA;
            alu_operator_o = bmu_pkg::ALU_B_SH3ADD;
          end
          // Zbb min/max
          {7'b0000101, 3'b100}: begin // min
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_MIN;
          end
          {7'b0000101, 3'b101}: begin // minu
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_MINU;
          end
          {7'b0000101, 3'b110}: begin // max
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_MAX;
          end
          {7'b0000101, 3'b111}: begin // maxu
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_MAXU;
          end
          // Zbb logic with inverted rs2
          {7'b0100000, 3'b111}: begin // andn
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ANDN;
          end
          {7'b0100000, 3'b110}: begin // orn
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ORN;
          end
          {7'b0100000, 3'b100}: begin // xnor
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_XNOR;
          end
          {7'b0110000, 3'b001}: begin // rol
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ROL;
          end
          {7'b0110000, 3'b101}: begin // ror
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ROR;
          end
          {7'b0000100, 3'b100}: begin // zext.h needs rs2 field x0
            illegal_insn_o = !RV32B_ZBB || (instr_rdata_i[24:20] != 5'b00000);
            alu_operator_o = bmu_pkg::ALU_B_ZEXT_H;
          end
          // Zbc
          {7'b0000101, 3'b001}: begin // clmul
            illegal_insn_o = !RV32B_ZBC;
            alu_operator_o = bmu_pkg::ALU_B_CLMUL;
          end
          {7'b0000101, 3'b011}: begin // clmulh
            illegal_insn_o = !RV32B_ZBC;
            alu_operator_o = bmu_pkg::ALU_B_CLMULH;
          end
          {7'b0000101, 3'b010}: begin // clmulr
            illegal_insn_o = !RV32B_ZBC;
            alu_operator_o = bmu_pkg::ALU_B_CLMULR;
          end
          // Zbs with index from rs2
          {7'b0010100, 3'b001}: begin // bset
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BSET;
          end
          {7'b0100100, 3'b001}: begin // bclr
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BCLR;
          end
          {7'b0110100, 3'b001}: begin // binv
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BINV;
          end
          {7'b0100100, 3'b101}: begin // bext
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BEXT;
          end
          default: illegal_insn_o = 1'b1;  // No match
        endcase
      end

      //////////////////////////////
      // Immediate and unary forms
      //////////////////////////////
      bmu_pkg::OPCODE_OPIMM: begin
        // Immediate forms take the index from the rs2 field
        alu_op_b_sel_o = bmu_pkg::OP_B_IMM;
        unique casez ({instr_rdata_i[31:25], instr_rdata_i[24:20], instr_rdata_i[14:12]})
          {7'b0110000, 5'b00000, 3'b001}: begin // clz
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_CLZ;
          end
          {7'b0110000, 5'b00001, 3'b001}: begin // ctz
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_CTZ;
          end
          {7'b0110000, 5'b00010, 3'b001}: begin // cpop
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_CPOP;
          end
          {7'b0110000, 5'b00100, 3'b001}: begin // sext.b
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_SEXT_B;
          end
          {7'b0110000, 5'b00101, 3'b001}: begin // sext.h
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_SEXT_H;
          end
          {7'b0010100, 5'b00111, 3'b101}: begin // orc.b
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ORC_B;
          end
          {7'b0110100, 5'b11000, 3'b101}: begin // rev8
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_REV8;
          end
          {7'b0110000, 5'b?????, 3'b101}: begin // rori
            illegal_insn_o = !RV32B_ZBB;
            alu_operator_o = bmu_pkg::ALU_B_ROR;
          end
          {7'b0010100, 5'b?????, 3'b001}: begin // bseti
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BSET;
          end
          {7'b0100100, 5'b?????, 3'b001}: begin // bclri
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BCLR;
          end
          {7'b0110100, 5'b?????, 3'b001}: begin // binvi
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BINV;
          end
          {7'b0100100, 5'b?????, 3'b101}: begin // bexti
            illegal_insn_o = !RV32B_ZBS;
            alu_operator_o = bmu_pkg::ALU_B_BEXT;
          end
          default: illegal_insn_o = 1'b1;  // No match
        endcase
      end

      default: illegal_insn_o = 1'b1;  // Not a B opcode
    endcase
  end

endmodule : bmu_b_decoder

//--- logic/bmu_b_alu.sv
// Bit-manipulation ALU
`timescale 1ns/1ps

module bmu_b_alu (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                issue_i,     // One-cycle start pulse
  input  logic                illegal_i,   // From decoder
  input  bmu_pkg::alu_op_e    operator_i,
  input  bmu_pkg::op_b_sel_e  op_b_sel_i,
  input  logic [31:0]         rs1_i,
  input  logic [31:0]         rs2_i,
  input  logic [4:0]          shamt_i,     // instr[24:20]
  output logic [31:0]         result_o,
  output logic                illegal_o,
  output logic                done_o
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  bit_idx;      // Index modulo 32
  logic [63:0] rol_tmp;
  logic [63:0] ror_tmp;
  logic [5:0]  clz_cnt;
  logic [5:0]  ctz_cnt;
  logic [5:0]  cpop_cnt;
  logic [31:0] orc_b;
  logic [63:0] clmul_prod;   // Full carry-less product
  logic [31:0] alu_result;
  logic        done_q;

  assign op_a    = rs1_i;
  assign op_b    = (op_b_sel_i == bmu_pkg::OP_B_IMM) ? {27'b0, shamt_i} : rs2_i;
  assign bit_idx = op_b[4:0];

  // Rotations via a doubled word
  assign rol_tmp = {op_a, op_a} << bit_idx;
  assign ror_tmp = {op_a, op_a} >> bit_idx;

  //////////////////////////////
  // Counts and products
  //////////////////////////////

  always_comb begin
    clz_cnt  = 6'd32;  // All-zero operand
    ctz_cnt  = 6'd32;
    cpop_cnt = 6'd0;
    for (int i = 0; i < 32; i++) begin
      if (op_a[i]) clz_cnt = 6'(31 - i);         // Highest set bit wins
      if (op_a[31 - i]) ctz_cnt = 6'(31 - i);    // Lowest set bit wins
      cpop_cnt = cpop_cnt + {5'b0, op_a[i]};
    end
  end

  // Each byte saturates to ones if any bit set
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      orc_b[8*b +: 8] = {8{|op_a[8*b +: 8]}};
    end
  end

  // Shift-and-XOR accumulate
  always_comb begin
    clmul_prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (op_b[i]) clmul_prod = clmul_prod ^ ({32'b0, op_a} << i);
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    unique case (operator_i)
      bmu_pkg::ALU_B_SH1ADD: alu_result = (op_a << 1) + op_b;
      bmu_pkg::ALU_B_SH2ADD: alu_result = (op_a << 2) + op_b;
      bmu_pkg::ALU_B_SH3ADD: alu_result = (op_a << 3) + op_b;
      bmu_pkg::ALU_B_MIN:    alu_result = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      bmu_pkg::ALU_B_MINU:   alu_result = (op_a < op_b) ? op_a : op_b;
      bmu_pkg::ALU_B_MAX:    alu_result = ($signed(op_a) < $signed(op_b)) ? op_b : op_a;
      bmu_pkg::ALU_B_MAXU:   alu_result = (op_a < op_b) ? op_b : op_a;
      bmu_pkg::ALU_B_ANDN:   alu_result = op_a & ~op_b;
      bmu_pkg::ALU_B_ORN:    alu_result = op_a | ~op_b;
      bmu_pkg::ALU_B_XNOR:   alu_result = ~(op_a ^ op_b);
      bmu_pkg::ALU_B_ROL:    alu_result = rol_tmp[63:32];
      bmu_pkg::ALU_B_ROR:    alu_result = ror_tmp[31:0];
      bmu_pkg::ALU_B_ZEXT_H: alu_result = {16'b0, op_a[15:0]};
      bmu_pkg::ALU_B_SEXT_B: alu_result = {{24{op_a[7]}}, op_a[7:0]};
      bmu_pkg::ALU_B_SEXT_H: alu_result = {{16{op_a[15]}}, op_a[15:0]};
      bmu_pkg::ALU_B_CLZ:    alu_result = {26'b0, clz_cnt};
      bmu_pkg::ALU_B_CTZ:    alu_result = {26'b0, ctz_cnt};
      bmu_pkg::ALU_B_CPOP:   alu_result = {26'b0, cpop_cnt};
      bmu_pkg::ALU_B_ORC_B:  alu_result = orc_b;
      bmu_pkg::ALU_B_REV8:   alu_result = {op_a[7:0], op_a[15:8], op_a[23:16], op_a[31:24]};
      bmu_pkg::ALU_B_CLMUL:  alu_result = clmul_prod[31:0];
      bmu_pkg::ALU_B_CLMULH: alu_result = clmul_prod[63:32];
      bmu_pkg::ALU_B_CLMULR: alu_result = clmul_prod[62:31];
      bmu_pkg::ALU_B_BSET:   alu_result = op_a | (32'd1 << bit_idx);
      bmu_pkg::ALU_B_BCLR:   alu_result = op_a & ~(32'd1 << bit_idx);
      bmu_pkg::ALU_B_BINV:   alu_result = op_a ^ (32'd1 << bit_idx);
      bmu_pkg::ALU_B_BEXT:   alu_result = {31'b0, op_a[bit_idx]};
      default:               alu_result = '0;  // Unused encodings
    endcase
  end

  //////////////////////////////
  // Result and flags
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_o  <= '0;
      illegal_o <= 1'b0;
      done_q    <= 1'b0;
    end else if (issue_i) begin
      done_q    <= 1'b1;
      illegal_o <= illegal_i;
      if (!illegal_i) begin
        result_o <= alu_result;  // Illegal op keeps the old result
      end
    end
  end

  // Done drops while a new op is in flight
  assign done_o = done_q && !issue_i;

endmodule : bmu_b_alu

//--- logic/bmu_regs.sv
// Wishbone register block
`timescale 1ns/1ps

module bmu_regs (
  input  logic        clk_i,
  input  logic        arst_n_i,
  // Wishbone classic slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,   // Byte offset
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  // Datapath side
  input  logic [31:0] result_i,
  input  logic        illegal_i,
  input  logic        done_i,
  output logic [31:0] instr_o,
  output logic [31:0] rs1_o,
  output logic [31:0] rs2_o,
  output logic        issue_o     // One cycle per INSTR write
);

  logic        access;    // New cycle accepted this edge
  logic        wr_en;
  logic [31:0] status_w;
  logic [31:0] rdata_w;

  // Ack low gates out a held stb
  assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en  = access && wb_we_i;

  //////////////////////////////
  // Handshake and registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o <= 1'b0;
      issue_o  <= 1'b0;
      rs1_o    <= '0;
      rs2_o    <= '0;
      instr_o  <= '0;
    end else begin
      wb_ack_o <= access;                                      // Single-cycle ack
      issue_o  <= wr_en && (wb_adr_i == bmu_pkg::REG_INSTR);  // Start the ALU
      if (wr_en) begin
        case (wb_adr_i)
          bmu_pkg::REG_RS1:   rs1_o   <= wb_dat_i;
          bmu_pkg::REG_RS2:   rs2_o   <= wb_dat_i;
          bmu_pkg::REG_INSTR: instr_o <= wb_dat_i;
          default: ;  // RESULT, STATUS and holes ignore writes
        endcase
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // STATUS word
  always_comb begin
    status_w                              = '0;
    status_w[bmu_pkg::STATUS_DONE_BIT]    = done_i;
    status_w[bmu_pkg::STATUS_ILLEGAL_BIT] = illegal_i;
  end

  always_comb begin
    case (wb_adr_i)
      bmu_pkg::REG_RS1:    rdata_w = rs1_o;
      bmu_pkg::REG_RS2:    rdata_w = rs2_o;
      bmu_pkg::REG_INSTR:  rdata_w = instr_o;
      bmu_pkg::REG_RESULT: rdata_w = result_i;
      bmu_pkg::REG_STATUS: rdata_w = status_w;
      default:             rdata_w = '0;  // Unmapped reads zero
    endcase
  end

  // Loaded with the ack and valid while ack is high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_dat_o <= '0;
    end else if (access) begin
      wb_dat_o <= rdata_w;
    end
  end

endmodule : bmu_regs

//--- logic/bmu_top.sv
// Bit-manipulation unit top
`timescale 1ns/1ps

module bmu_top #(
  parameter bmu_pkg::b_ext_e B_EXT = bmu_pkg::ZBA_ZBB_ZBC_ZBS
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  logic [31:0]        instr;
  logic [31:0]        rs1;
  logic [31:0]        rs2;
  logic               issue;
  logic [31:0]        result;
  logic               illegal;
  logic               done;
  logic               dec_illegal;   // Decoder view of instr
  bmu_pkg::alu_op_e   dec_operator;
  bmu_pkg::op_b_sel_e dec_op_b_sel;

  // Host registers
  bmu_regs u_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .result_i  (result),
    .illegal_i (illegal),
    .done_i    (done),
    .instr_o   (instr),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .issue_o   (issue)
  );

  bmu_b_decoder #(
    .B_EXT (B_EXT)
  ) u_decoder (
    .instr_rdata_i  (instr),
    .illegal_insn_o (dec_illegal),
    .alu_operator_o (dec_operator),
    .alu_op_b_sel_o (dec_op_b_sel)
  );

  // Immediate index straight from the instruction
  bmu_b_alu u_alu (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .issue_i    (issue),
    .illegal_i  (dec_illegal),
    .operator_i (dec_operator),
    .op_b_sel_i (dec_op_b_sel),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .shamt_i    (instr[24:20]),
    .result_o   (result),
    .illegal_o  (illegal),
    .done_o     (done)
  );

endmodule : bmu_top

//--- tests/bmu_checker.sv
// Handshake and issue checker
`timescale 1ns/1ps

module bmu_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,   // Slave ack seen from the bus
  input logic issue_i,    // Register block start pulse
  input logic done_i      // ALU done flag
);

  //////////////////////////////
  // Wishbone handshake
  //////////////////////////////

  // Ack only inside a strobed cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else $error("Ack raised without cyc and stb");

  ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_i |=> !wb_ack_i)  // One-cycle ack
    else $error("Ack held for two cycles");

  //////////////////////////////
  // Issue timing
  //////////////////////////////

  // Done drops during issue and rises on the next edge
  done_after_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_i |=> $rose(done_i))
    else $error("Done did not rise one cycle after issue");

  issue_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_i |=> !issue_i)
    else $error("Issue held for two cycles");

endmodule : bmu_checker

bind bmu_top bmu_checker u_checker (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_i (wb_ack_o),
  .issue_i  (issue),
  .done_i   (done)
);

//--- tests/bmu_tb.sv
// Bit-manipulation unit testbench
`timescale 1ns/1ps

module bmu_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int NUM_ACCESSES = 510;  // Bus accesses over all tests
  localparam int WATCHDOG_NS  = NUM_ACCESSES * 6 * CLK_PERIOD + 2000;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  int          errors;
  int          checks;
  logic [31:0] last_result;  // Model view of RESULT

  bmu_top dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Bus driver
  //////////////////////////////

  // Stb is held through the ack cycle, then dropped
  task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);  // Watchdog covers a lost ack
    rdata = wb_dat_r;                // Valid while ack is high
    @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  //////////////////////////////
  // Encoding and model
  //////////////////////////////

  // OP form with rs1=x1 rs2=x2 rd=x3
  function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, bmu_pkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] opimm_word(input logic [6:0] f7, input logic [4:0] f20,
                                             input logic [2:0] f3);
    return {f7, f20, 5'd1, f3, 5'd3, bmu_pkg::OPCODE_OPIMM};
  endfunction

  // Expected result from the bit-manipulation rules
  function automatic logic [31:0] model_result(input bmu_pkg::alu_op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    logic [63:0] prod;
    int          idx;
    int          cnt;
    r    = '0;
    prod = '0;
    idx  = int'(b[4:0]);  // Index modulo 32
    cnt  = 0;
    // Product bit k is the XOR of a[i] & b[k-i]
    for (int k = 0; k < 63; k++) begin
      for (int i = 0; i < 32; i++) begin
        if (k - i >= 0 && k - i < 32) prod[k] = prod[k] ^ (a[i] & b[k - i]);
      end
    end
    case (op)
      bmu_pkg::ALU_B_SH1ADD: r = {a[30:0], 1'b0} + b;
      bmu_pkg::ALU_B_SH2ADD: r = {a[29:0], 2'b0} + b;
      bmu_pkg::ALU_B_SH3ADD: r = {a[28:0], 3'b0} + b;
      bmu_pkg::ALU_B_MIN:    r = ($signed(a) <= $signed(b)) ? a : b;
      bmu_pkg::ALU_B_MINU:   r = (a <= b) ? a : b;
      bmu_pkg::ALU_B_MAX:    r = ($signed(a) >= $signed(b)) ? a : b;
      bmu_pkg::ALU_B_MAXU:   r = (a >= b) ? a : b;
      bmu_pkg::ALU_B_ANDN:   r = a & ~b;
      bmu_pkg::ALU_B_ORN:    r = a | ~b;
      bmu_pkg::ALU_B_XNOR:   r = a ^ ~b;
      bmu_pkg::ALU_B_ROL:    for (int i = 0; i < 32; i++) r[(i + idx) % 32] = a[i];
      bmu_pkg::ALU_B_ROR:    for (int i = 0; i < 32; i++) r[i] = a[(i + idx) % 32];
      bmu_pkg::ALU_B_ZEXT_H: r = a & 32'h0000_FFFF;
      bmu_pkg::ALU_B_SEXT_B: r = a[7] ? (a | 32'hFFFF_FF00) : (a & 32'h0000_00FF);
      bmu_pkg::ALU_B_SEXT_H: r = a[15] ? (a | 32'hFFFF_0000) : (a & 32'h0000_FFFF);
      bmu_pkg::ALU_B_CLZ: begin
        for (int i = 31; i >= 0 && !a[i]; i--) cnt++;  // Walk down to first one
        r = 32'(cnt);
      end
      bmu_pkg::ALU_B_CTZ: begin
        for (int i = 0; i < 32 && !a[i]; i++) cnt++;
        r = 32'(cnt);
      end
      bmu_pkg::ALU_B_CPOP: begin
        for (int i = 0; i < 32; i++) begin
          if (a[i]) cnt++;
        end
        r = 32'(cnt);
      end
      bmu_pkg::ALU_B_ORC_B: begin
        for (int k = 0; k < 4; k++) begin
          r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hFF : 8'h00;
        end
      end
      bmu_pkg::ALU_B_REV8:   for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
      bmu_pkg::ALU_B_CLMUL:  r = prod[31:0];
      bmu_pkg::ALU_B_CLMULH: r = prod[63:32];
      bmu_pkg::ALU_B_CLMULR: r = prod[62:31];
      bmu_pkg::ALU_B_BSET: begin
        r      = a;
        r[idx] = 1'b1;
      end
      bmu_pkg::ALU_B_BCLR: begin
        r      = a;
        r[idx] = 1'b0;
      end
      bmu_pkg::ALU_B_BINV: begin
        r      = a;
        r[idx] = ~a[idx];
      end
      bmu_pkg::ALU_B_BEXT:   r = {31'b0, a[idx]};
      default:               r = '0;
    endcase
    return r;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  // Flags as seen in the STATUS word
  task automatic check_flag(input string name, input logic exp_illegal, input logic exp_done,
                            input logic [31:0] status);
    logic act_illegal;
    logic act_done;
    act_illegal = status[bmu_pkg::STATUS_ILLEGAL_BIT];
    act_done    = status[bmu_pkg::STATUS_DONE_BIT];
    checks++;
    if (act_illegal !== exp_illegal || act_done !== exp_done || status[31:2] !== '0) begin
      errors++;
      $display("ERR %s: expected illegal=%0b done=%0b, actual illegal=%0b done=%0b (%08h)",
               name, exp_illegal, exp_done, act_illegal, act_done, status);
    end
  endtask

  //////////////////////////////
  // Operation sequences
  //////////////////////////////

  task automatic run_op(input string name, input bmu_pkg::alu_op_e op, input logic [31:0] instr,
                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] op_b;
    logic [31:0] exp;
    logic [31:0] got;
    op_b = (instr[6:0] == bmu_pkg::OPCODE_OPIMM) ? {27'b0, instr[24:20]} : b;  // Imm ignores RS2
    exp  = model_result(op, a, op_b);
    wb_write(bmu_pkg::REG_RS1, a);
    wb_write(bmu_pkg::REG_RS2, b);
    wb_write(bmu_pkg::REG_INSTR, instr);
    wb_read(bmu_pkg::REG_RESULT, got);
    check_word(name, exp, got);
    wb_read(bmu_pkg::REG_STATUS, got);
    check_flag({name, " status"}, 1'b0, 1'b1, got);
    last_result = exp;
  endtask

  // Illegal word keeps the previous result
  task automatic run_illegal(input string name, input logic [31:0] instr);
    logic [31:0] got;
    wb_write(bmu_pkg::REG_INSTR, instr);
    wb_read(bmu_pkg::REG_RESULT, got);
    check_word(name, last_result, got);
    wb_read(bmu_pkg::REG_STATUS, got);
    check_flag({name, " status"}, 1'b1, 1'b1, got);
  endtask

  task automatic reset_and_regs();
    logic [31:0] got;
    logic [31:0] v1;
    logic [31:0] v2;
    v1 = $urandom;
    v2 = $urandom;
    wb_read(bmu_pkg::REG_RESULT, got);
    check_word("reset result", 32'h0, got);
    wb_read(bmu_pkg::REG_STATUS, got);
    check_flag("reset status", 1'b0, 1'b0, got);
    wb_read(bmu_pkg::REG_INSTR, got);
    check_word("reset instr", 32'h0, got);
    wb_write(bmu_pkg::REG_RS1, v1);
    wb_write(bmu_pkg::REG_RS2, v2);
    wb_read(bmu_pkg::REG_RS1, got);
    check_word("rs1 readback", v1, got);
    wb_read(bmu_pkg::REG_RS2, got);
    check_word("rs2 readback", v2, got);
    wb_write(5'h14, 32'hDEAD_BEEF);         // Write to a hole is dropped
    wb_read(5'h14, got);
    check_word("unmapped read", 32'h0, got);
    wb_write(bmu_pkg::REG_RESULT, v1);      // Read-only
    wb_read(bmu_pkg::REG_RESULT, got);
    check_word("result read-only", 32'h0, got);
  endtask

  task automatic reg_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    for (int n = 0; n < 2; n++) begin
      a = $urandom;
      b = (n == 0) ? (a ^ 32'h8000_0000) : $urandom;  // First round flips the sign
      run_op("sh1add", bmu_pkg::ALU_B_SH1ADD, op_word(7'b0010000, 3'b010), a, b);
      run_op("sh2add", bmu_pkg::ALU_B_SH2ADD, op_word(7'b0010000, 3'b100), a, b);
      run_op("sh3add", bmu_pkg::ALU_B_SH3ADD, op_word(7'b0010000, 3'b110), a, b);
      run_op("min", bmu_pkg::ALU_B_MIN, op_word(7'b0000101, 3'b100), a, b);
      run_op("minu", bmu_pkg::ALU_B_MINU, op_word(7'b0000101, 3'b101), a, b);
      run_op("max", bmu_pkg::ALU_B_MAX, op_word(7'b0000101, 3'b110), a, b);
      run_op("maxu", bmu_pkg::ALU_B_MAXU, op_word(7'b0000101, 3'b111), a, b);
      run_op("andn", bmu_pkg::ALU_B_ANDN, op_word(7'b0100000, 3'b111), a, b);
      run_op("orn", bmu_pkg::ALU_B_ORN, op_word(7'b0100000, 3'b110), a, b);
      run_op("xnor", bmu_pkg::ALU_B_XNOR, op_word(7'b0100000, 3'b100), a, b);
      run_op("rol", bmu_pkg::ALU_B_ROL, op_word(7'b0110000, 3'b001), a, b);
      run_op("ror", bmu_pkg::ALU_B_ROR, op_word(7'b0110000, 3'b101), a, b);
      run_op("bset", bmu_pkg::ALU_B_BSET, op_word(7'b0010100, 3'b001), a, b);
      run_op("bclr", bmu_pkg::ALU_B_BCLR, op_word(7'b0100100, 3'b001), a, b);
      run_op("binv", bmu_pkg::ALU_B_BINV, op_word(7'b0110100, 3'b001), a, b);
      run_op("bext", bmu_pkg::ALU_B_BEXT, op_word(7'b0100100, 3'b101), a, b);
    end
  endtask

  task automatic imm_and_unary_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    logic [31:0] zext_h;
    zext_h = op_word(7'b0000100, 3'b100) & 32'hFE0F_FFFF;  // rs2 field cleared
    for (int n = 0; n < 4; n++) begin
      a  = (n == 0) ? 32'h0 : (n == 1) ? 32'h8000_0001 : (n == 2) ? 32'h0000_8080 : $urandom;
      b  = $urandom;
      sh = (n == 0) ? 5'd0 : (n == 1) ? 5'd31 : 5'($urandom);
      run_op("rori", bmu_pkg::ALU_B_ROR, opimm_word(7'b0110000, sh, 3'b101), a, b);
      run_op("bseti", bmu_pkg::ALU_B_BSET, opimm_word(7'b0010100, sh, 3'b001), a, b);
      run_op("bclri", bmu_pkg::ALU_B_BCLR, opimm_word(7'b0100100, sh, 3'b001), a, b);
      run_op("binvi", bmu_pkg::ALU_B_BINV, opimm_word(7'b0110100, sh, 3'b001), a, b);
      run_op("bexti", bmu_pkg::ALU_B_BEXT, opimm_word(7'b0100100, sh, 3'b101), a, b);
      run_op("clz", bmu_pkg::ALU_B_CLZ, opimm_word(7'b0110000, 5'd0, 3'b001), a, b);
      run_op("ctz", bmu_pkg::ALU_B_CTZ, opimm_word(7'b0110000, 5'd1, 3'b001), a, b);
      run_op("cpop", bmu_pkg::ALU_B_CPOP, opimm_word(7'b0110000, 5'd2, 3'b001), a, b);
      run_op("orc.b", bmu_pkg::ALU_B_ORC_B, opimm_word(7'b0010100, 5'd7, 3'b101), a, b);
      run_op("rev8", bmu_pkg::ALU_B_REV8, opimm_word(7'b0110100, 5'd24, 3'b101), a, b);
      run_op("sext.b", bmu_pkg::ALU_B_SEXT_B, opimm_word(7'b0110000, 5'd4, 3'b001), a, b);
      run_op("sext.h", bmu_pkg::ALU_B_SEXT_H, opimm_word(7'b0110000, 5'd5, 3'b001), a, b);
      run_op("zext.h", bmu_pkg::ALU_B_ZEXT_H, zext_h, a, b);
    end
  endtask

  task automatic carryless_ops();
    logic [31:0] a;
    logic [31:0] b;
    for (int n = 0; n < 4; n++) begin
      a = $urandom;
      b = $urandom;
      run_op("clmul", bmu_pkg::ALU_B_CLMUL, op_word(7'b0000101, 3'b001), a, b);
      run_op("clmulh", bmu_pkg::ALU_B_CLMULH, op_word(7'b0000101, 3'b011), a, b);
      run_op("clmulr", bmu_pkg::ALU_B_CLMULR, op_word(7'b0000101, 3'b010), a, b);
    end
  endtask

  task automatic illegal_words();
    run_op("andn before illegal", bmu_pkg::ALU_B_ANDN, op_word(7'b0100000, 3'b111),
           $urandom, $urandom);
    run_illegal("lui opcode", 32'h1234_5037);
    run_illegal("unmatched funct7", op_word(7'b1111111, 3'b000));
    run_illegal("zext.h rs2 nonzero", op_word(7'b0000100, 3'b100));
    // Legal op clears the flag again
    run_op("xnor after illegal", bmu_pkg::ALU_B_XNOR, op_word(7'b0100000, 3'b100),
           $urandom, $urandom);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h5df23c4e));
    errors      = 0;
    checks      = 0;
    last_result = 32'h0;
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = 5'h0;
    wb_dat_w    = 32'h0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;  // Release on a falling edge
    reset_and_regs();
    reg_reg_ops();
    imm_and_unary_ops();
    carryless_ops();
    illegal_words();
    repeat (2) @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized from the access count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : bmu_tb

//--- bmu_top.f
logic/bmu_pkg.sv
logic/bmu_b_decoder.sv
logic/bmu_b_alu.sv
logic/bmu_regs.sv
logic/bmu_top.sv
tests/bmu_checker.sv
tests/bmu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the BMU testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 -f bmu_top.f --top-module bmu_tb

status=0
./obj_dir/Vbmu_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG" || [ "$status" -ne 0 ]; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation passed"
